// File: include/wb_l1_params.svh
/*
 * Bus widths and the arbiter timeout for the shared Wishbone master
 */

`ifndef WB_L1_PARAMS_SVH
`define WB_L1_PARAMS_SVH

`define WB_L1_DATA_W 32
`define WB_L1_ADR_W 30
`define WB_L1_SEL_W 4
// Cycles without ack or err before the arbiter gives up
`define WB_L1_BUS_TIMEOUT 64

`endif

// File: logic/wb_l1_pkg.sv
/*
 * Shared types of the L1 bus wrapper
 * Address, data and select vectors, access size codes,
 * requester and arbiter state enums
 */

`include "wb_l1_params.svh"

package wb_l1_pkg;

    // Byte address as issued by the core
    typedef logic [31:0] byte_addr_t;

    // Wishbone word address, data and select
    typedef logic [`WB_L1_ADR_W-1:0] wb_adr_t;
    typedef logic [`WB_L1_DATA_W-1:0] word_t;
    typedef logic [`WB_L1_SEL_W-1:0] sel_t;

    // Load/store access size, RISC-V funct3[1:0] encoding
    typedef logic [1:0] access_size_t;
    localparam access_size_t SIZE_BYTE = 2'b00;
    localparam access_size_t SIZE_HALF = 2'b01;
    localparam access_size_t SIZE_WORD = 2'b10;

    typedef enum logic [1:0] {
        PORT_IDLE = 2'b00,
        PORT_BUS  = 2'b01,
        PORT_RESP = 2'b10
    } port_state_t;

    typedef enum logic {
        ARB_IDLE  = 1'b0,
        ARB_CYCLE = 1'b1
    } arb_state_t;

endpackage

// File: logic/fetch_port.sv
/*
 * Instruction fetch requester
 * Holds one word read toward the arbiter and returns it to the core
 */

`timescale 1ns/1ps

module fetch_port (
    input  logic                   clk,
    input  logic                   rst,

    input  logic                   if_req,
    input  wb_l1_pkg::byte_addr_t  if_addr,
    output logic                   if_busy,
    output logic                   if_rsp_valid,
    output wb_l1_pkg::word_t       if_rsp_data,
    output logic                   if_rsp_err,

    output logic                   bus_req,
    output wb_l1_pkg::wb_adr_t     bus_adr,
    input  logic                   bus_done,
    input  wb_l1_pkg::word_t       bus_rdata,
    input  logic                   bus_err
);

    wb_l1_pkg::port_state_t state;

    always_ff @(posedge clk) begin
        if (rst) begin
            state <= wb_l1_pkg::PORT_IDLE;
        end else begin
            case (state)
                wb_l1_pkg::PORT_IDLE: if (if_req) state <= wb_l1_pkg::PORT_BUS;
                wb_l1_pkg::PORT_BUS:  if (bus_done) state <= wb_l1_pkg::PORT_RESP;
                default:              state <= wb_l1_pkg::PORT_IDLE;
            endcase
        end
    end

    // Fetches are word aligned, low address bits are ignored
    always_ff @(posedge clk) begin
        if (state == wb_l1_pkg::PORT_IDLE && if_req) begin
            bus_adr <= if_addr[31:2];
        end
        if (bus_done) begin
            if_rsp_data <= bus_rdata;
            if_rsp_err <= bus_err;
        end
    end

    assign bus_req = (state == wb_l1_pkg::PORT_BUS);
    assign if_busy = (state != wb_l1_pkg::PORT_IDLE);
    assign if_rsp_valid = (state == wb_l1_pkg::PORT_RESP);

    // Arbiter only answers a request that is still pending
    done_needs_req: assert property (@(posedge clk) disable iff (rst)
        bus_done |-> bus_req);

endmodule

// File: logic/data_port.sv
/*
 * Load/store requester
 * Lane selection and store data replication, misalignment check,
 * load lane extraction with sign or zero extension
 */

`timescale 1ns/1ps

module data_port (
    input  logic                     clk,
    input  logic                     rst,

    input  logic                     ls_req,
    input  wb_l1_pkg::byte_addr_t    ls_addr,
    input  logic                     ls_we,
    input  wb_l1_pkg::access_size_t  ls_size,
    input  logic                     ls_unsigned,
    input  wb_l1_pkg::word_t         ls_wdata,
    output logic                     ls_busy,
    output logic                     ls_rsp_valid,
    output wb_l1_pkg::word_t         ls_rsp_data,
    output logic                     ls_rsp_err,

    output logic                     bus_req,
    output wb_l1_pkg::wb_adr_t       bus_adr,
    output logic                     bus_we,
    output wb_l1_pkg::sel_t          bus_sel,
    output wb_l1_pkg::word_t         bus_wdata,
    input  logic                     bus_done,
    input  wb_l1_pkg::word_t         bus_rdata,
    input  logic                     bus_err
);

    wb_l1_pkg::port_state_t state;
    wb_l1_pkg::access_size_t size_r;
    wb_l1_pkg::sel_t acc_sel;
    wb_l1_pkg::word_t acc_wdata;
    wb_l1_pkg::word_t lane_data;
    wb_l1_pkg::word_t load_data;
    logic [1:0] offset_r;
    logic unsigned_r;
    logic misaligned;
    logic accept;
    logic sign_ext;

    assign accept = (state == wb_l1_pkg::PORT_IDLE) && ls_req;

    // Byte lanes and store data from size and low address bits
    always_comb begin
        acc_sel = '0;
        acc_wdata = ls_wdata;
        misaligned = 1'b0;
        case (ls_size)
            wb_l1_pkg::SIZE_BYTE: begin
                acc_sel = 4'b0001 << ls_addr[1:0];
                acc_wdata = {4{ls_wdata[7:0]}};
            end
            wb_l1_pkg::SIZE_HALF: begin
                acc_sel = 4'b0011 << ls_addr[1:0];
                acc_wdata = {2{ls_wdata[15:0]}};
                misaligned = ls_addr[0];
            end
            wb_l1_pkg::SIZE_WORD: begin
                acc_sel = 4'b1111;
                misaligned = (ls_addr[1:0] != 2'b00);
            end
            // Reserved size code
            default: misaligned = 1'b1;
        endcase
    end

    // Misaligned requests skip the bus and answer next cycle
    always_ff @(posedge clk) begin
        if (rst) begin
            state <= wb_l1_pkg::PORT_IDLE;
        end else begin
            case (state)
                wb_l1_pkg::PORT_IDLE: begin
                    if (ls_req) begin
                        state <= misaligned ? wb_l1_pkg::PORT_RESP : wb_l1_pkg::PORT_BUS;
                    end
                end
                wb_l1_pkg::PORT_BUS: if (bus_done) state <= wb_l1_pkg::PORT_RESP;
                default:             state <= wb_l1_pkg::PORT_IDLE;
            endcase
        end
    end

    // Shift addressed lanes down, then extend
    always_comb begin
        lane_data = bus_rdata >> {offset_r, 3'b000};
        sign_ext = ~unsigned_r;
        case (size_r)
            wb_l1_pkg::SIZE_BYTE: load_data = {{24{sign_ext & lane_data[7]}}, lane_data[7:0]};
            wb_l1_pkg::SIZE_HALF: load_data = {{16{sign_ext & lane_data[15]}}, lane_data[15:0]};
            default:              load_data = lane_data;
        endcase
    end

    always_ff @(posedge clk) begin
        if (accept) begin
            bus_adr <= ls_addr[31:2];
            bus_we <= ls_we;
            bus_sel <= acc_sel;
            bus_wdata <= acc_wdata;
            size_r <= ls_size;
            offset_r <= ls_addr[1:0];
            unsigned_r <= ls_unsigned;
            ls_rsp_data <= '0;
            ls_rsp_err <= misaligned;
        end
        if (bus_done) begin
            // Stores answer with zero data
            ls_rsp_data <= bus_we ? '0 : load_data;
            ls_rsp_err <= bus_err;
        end
    end

    assign bus_req = (state == wb_l1_pkg::PORT_BUS);
    assign ls_busy = (state != wb_l1_pkg::PORT_IDLE);
    assign ls_rsp_valid = (state == wb_l1_pkg::PORT_RESP);

    sel_nonzero: assert property (@(posedge clk) disable iff (rst)
        bus_req |-> (bus_sel != '0));

endmodule

// File: logic/wb_arbiter.sv
/*
 * Round-robin arbiter onto one Wishbone classic master
 * Registered bus outputs, one single cycle at a time,
 * timeout on a silent slave
 */

`timescale 1ns/1ps
`include "wb_l1_params.svh"

module wb_arbiter (
    input  logic                 clk,
    input  logic                 rst,

    input  logic                 if_bus_req,
    input  wb_l1_pkg::wb_adr_t   if_bus_adr,
    output logic                 if_bus_done,

    input  logic                 ls_bus_req,
    input  wb_l1_pkg::wb_adr_t   ls_bus_adr,
    input  logic                 ls_bus_we,
    input  wb_l1_pkg::sel_t      ls_bus_sel,
    input  wb_l1_pkg::word_t     ls_bus_wdata,
    output logic                 ls_bus_done,

    output wb_l1_pkg::word_t     bus_rdata,
    output logic                 bus_err,

    output wb_l1_pkg::wb_adr_t   wb_adr,
    output wb_l1_pkg::word_t     wb_dat_w,
    output wb_l1_pkg::sel_t      wb_sel,
    output logic                 wb_cyc,
    output logic                 wb_stb,
    output logic                 wb_we,
    input  wb_l1_pkg::word_t     wb_dat_r,
    input  logic                 wb_ack,
    input  logic                 wb_err
);

    localparam int CNT_W = $clog2(`WB_L1_BUS_TIMEOUT);

    wb_l1_pkg::arb_state_t state;
    logic [CNT_W-1:0] wait_cnt;
    logic owner_ls;
    logic if_want;
    logic ls_want;
    logic grant_ls;
    logic timeout;
    logic cycle_end;

    // A requester still sees its own done pulse, so it is not pending then
    assign if_want = if_bus_req & ~if_bus_done;
    assign ls_want = ls_bus_req & ~ls_bus_done;

    // owner_ls doubles as the last-grant bit
    assign grant_ls = ls_want & (~if_want | ~owner_ls);

    assign timeout = (wait_cnt == CNT_W'(`WB_L1_BUS_TIMEOUT - 1));
    assign cycle_end = wb_ack | wb_err | timeout;

    always_ff @(posedge clk) begin
        if (rst) begin
            state <= wb_l1_pkg::ARB_IDLE;
            owner_ls <= 1'b0;
            wait_cnt <= '0;
            wb_cyc <= 1'b0;
            wb_stb <= 1'b0;
            if_bus_done <= 1'b0;
            ls_bus_done <= 1'b0;
        end else begin
            if_bus_done <= 1'b0;
            ls_bus_done <= 1'b0;
            case (state)
                wb_l1_pkg::ARB_IDLE: begin
                    wait_cnt <= '0;
                    if (if_want | ls_want) begin
                        state <= wb_l1_pkg::ARB_CYCLE;
                        owner_ls <= grant_ls;
                        wb_cyc <= 1'b1;
                        wb_stb <= 1'b1;
                    end
                end
                default: begin
                    wait_cnt <= wait_cnt + 1'b1;
                    if (cycle_end) begin
                        state <= wb_l1_pkg::ARB_IDLE;
                        wb_cyc <= 1'b0;
                        wb_stb <= 1'b0;
                        if_bus_done <= ~owner_ls;
                        ls_bus_done <= owner_ls;
                    end
                end
            endcase
        end
    end

    // Winner fields and returned data
    always_ff @(posedge clk) begin
        if (state == wb_l1_pkg::ARB_IDLE && (if_want | ls_want)) begin
            if (grant_ls) begin
                wb_adr <= ls_bus_adr;
                wb_dat_w <= ls_bus_wdata;
                wb_sel <= ls_bus_sel;
                wb_we <= ls_bus_we;
            end else begin
                // Fetch is always a full word read
                wb_adr <= if_bus_adr;
                wb_dat_w <= '0;
                wb_sel <= '1;
                wb_we <= 1'b0;
            end
        end
        if (state == wb_l1_pkg::ARB_CYCLE && cycle_end) begin
            bus_rdata <= wb_dat_r;
            bus_err <= wb_err | (timeout & ~wb_ack);
        end
    end

    cyc_eq_stb: assert property (@(posedge clk) disable iff (rst)
        wb_cyc == wb_stb);

    // Master holds the cycle until the slave answers
    master_stable: assert property (@(posedge clk) disable iff (rst)
        (wb_cyc && !wb_ack && !wb_err && !timeout) |=>
            (wb_cyc && $stable(wb_adr) && $stable(wb_dat_w)
             && $stable(wb_sel) && $stable(wb_we)));

endmodule

// File: logic/l1_bus_wrapper.sv
/*
 * Top of the shared instruction and data bus
 * Fetch and load/store requesters merged onto one Wishbone master
 */

`timescale 1ns/1ps

module l1_bus_wrapper (
    input  logic                     clk,
    input  logic                     rst,

    // Instruction fetch
    input  logic                     if_req,
    input  wb_l1_pkg::byte_addr_t    if_addr,
    output logic                     if_busy,
    output logic                     if_rsp_valid,
    output wb_l1_pkg::word_t         if_rsp_data,
    output logic                     if_rsp_err,

    // Load/store
    input  logic                     ls_req,
    input  wb_l1_pkg::byte_addr_t    ls_addr,
    input  logic                     ls_we,
    input  wb_l1_pkg::access_size_t  ls_size,
    input  logic                     ls_unsigned,
    input  wb_l1_pkg::word_t         ls_wdata,
    output logic                     ls_busy,
    output logic                     ls_rsp_valid,
    output wb_l1_pkg::word_t         ls_rsp_data,
    output logic                     ls_rsp_err,

    // Wishbone classic master
    output wb_l1_pkg::wb_adr_t       wb_adr,
    output wb_l1_pkg::word_t         wb_dat_w,
    output wb_l1_pkg::sel_t          wb_sel,
    output logic                     wb_cyc,
    output logic                     wb_stb,
    output logic                     wb_we,
    input  wb_l1_pkg::word_t         wb_dat_r,
    input  logic                     wb_ack,
    input  logic                     wb_err
);

    logic if_bus_req;
    wb_l1_pkg::wb_adr_t if_bus_adr;
    logic if_bus_done;

    logic ls_bus_req;
    wb_l1_pkg::wb_adr_t ls_bus_adr;
    logic ls_bus_we;
    wb_l1_pkg::sel_t ls_bus_sel;
    wb_l1_pkg::word_t ls_bus_wdata;
    logic ls_bus_done;

    // Shared return path, qualified by each done pulse
    wb_l1_pkg::word_t bus_rdata;
    logic bus_err;

    fetch_port u_fetch_port (
        .clk          (clk),
        .rst          (rst),
        .if_req       (if_req),
        .if_addr      (if_addr),
        .if_busy      (if_busy),
        .if_rsp_valid (if_rsp_valid),
        .if_rsp_data  (if_rsp_data),
        .if_rsp_err   (if_rsp_err),
        .bus_req      (if_bus_req),
        .bus_adr      (if_bus_adr),
        .bus_done     (if_bus_done),
        .bus_rdata    (bus_rdata),
        .bus_err      (bus_err)
    );

    data_port u_data_port (
        .clk          (clk),
        .rst          (rst),
        .ls_req       (ls_req),
        .ls_addr      (ls_addr),
        .ls_we        (ls_we),
        .ls_size      (ls_size),
        .ls_unsigned  (ls_unsigned),
        .ls_wdata     (ls_wdata),
        .ls_busy      (ls_busy),
        .ls_rsp_valid (ls_rsp_valid),
        .ls_rsp_data  (ls_rsp_data),
        .ls_rsp_err   (ls_rsp_err),
        .bus_req      (ls_bus_req),
        .bus_adr      (ls_bus_adr),
        .bus_we       (ls_bus_we),
        .bus_sel      (ls_bus_sel),
        .bus_wdata    (ls_bus_wdata),
        .bus_done     (ls_bus_done),
        .bus_rdata    (bus_rdata),
        .bus_err      (bus_err)
    );

    wb_arbiter u_wb_arbiter (
        .clk          (clk),
        .rst          (rst),
        .if_bus_req   (if_bus_req),
        .if_bus_adr   (if_bus_adr),
        .if_bus_done  (if_bus_done),
        .ls_bus_req   (ls_bus_req),
        .ls_bus_adr   (ls_bus_adr),
        .ls_bus_we    (ls_bus_we),
        .ls_bus_sel   (ls_bus_sel),
        .ls_bus_wdata (ls_bus_wdata),
        .ls_bus_done  (ls_bus_done),
        .bus_rdata    (bus_rdata),
        .bus_err      (bus_err),
        .wb_adr       (wb_adr),
        .wb_dat_w     (wb_dat_w),
        .wb_sel       (wb_sel),
        .wb_cyc       (wb_cyc),
        .wb_stb       (wb_stb),
        .wb_we        (wb_we),
        .wb_dat_r     (wb_dat_r),
        .wb_ack       (wb_ack),
        .wb_err       (wb_err)
    );

endmodule

// File: verification/tb_clock.sv
/*
 * Testbench clock source, 4 ns period
 */

`timescale 1ns/1ps

module tb_clock (
    output logic clk
);

    initial begin
        clk = 1'b0;
    end

    always #2 clk = ~clk;

endmodule

// File: verification/tb_checker.sv
/*
 * Response monitor for the L1 bus wrapper
 * Shadow memory from observed writes, response prediction,
 * Wishbone protocol and arbitration fairness checks
 */

`timescale 1ns/1ps

module tb_checker (
    input  logic                     clk,
    input  logic                     rst,
    input  logic                     if_req,
    input  wb_l1_pkg::byte_addr_t    if_addr,
    input  logic                     if_busy,
    input  logic                     if_rsp_valid,
    input  wb_l1_pkg::word_t         if_rsp_data,
    input  logic                     if_rsp_err,
    input  logic                     ls_req,
    input  wb_l1_pkg::byte_addr_t    ls_addr,
    input  logic                     ls_we,
    input  wb_l1_pkg::access_size_t  ls_size,
    input  logic                     ls_unsigned,
    input  wb_l1_pkg::word_t         ls_wdata,
    input  logic                     ls_busy,
    input  logic                     ls_rsp_valid,
    input  wb_l1_pkg::word_t         ls_rsp_data,
    input  logic                     ls_rsp_err,
    input  wb_l1_pkg::wb_adr_t       wb_adr,
    input  wb_l1_pkg::word_t         wb_dat_w,
    input  wb_l1_pkg::sel_t          wb_sel,
    input  logic                     wb_cyc,
    input  logic                     wb_stb,
    input  logic                     wb_we,
    input  logic                     wb_ack,
    input  logic                     wb_err,
    input  logic                     end_check,
    output int                       data_errors,
    output int                       fault_errors
);

    wb_l1_pkg::word_t shadow [0:255];

    // Pending fetch
    logic f_pending;
    logic [7:0] f_idx;
    int f_accept;
    int f_ends;

    // Pending load or store
    logic l_pending;
    logic [7:0] l_idx;
    logic [1:0] l_off;
    wb_l1_pkg::access_size_t l_size;
    logic l_uns;
    logic l_we;
    logic l_mis;
    wb_l1_pkg::word_t l_wdata;
    int l_accept;
    int l_ends;

    // Arbitration order
    logic both_wait;
    logic end_both;
    logic have_owner;
    logic last_ls;

    int cycle_no;
    int bus_starts;
    int expected_starts;
    logic seen_req;
    logic prev_cyc;
    logic prev_end;
    wb_l1_pkg::wb_adr_t prev_adr;
    wb_l1_pkg::word_t prev_dat;
    wb_l1_pkg::sel_t prev_sel;
    logic prev_we;
    wb_l1_pkg::word_t exp_word;
    wb_l1_pkg::word_t lane_mask;
    wb_l1_pkg::sel_t exp_sel;

    // Same contents the slave memory starts with
    function automatic wb_l1_pkg::word_t fill_word(input logic [7:0] idx);
        return {idx ^ 8'ha5, idx + 8'h3c, ~idx, idx * 8'd7};
    endfunction

    // Slave answers err for the top quarter of the memory
    function automatic logic region_err(input logic [7:0] idx);
        return idx[7:6] == 2'b11;
    endfunction

    function automatic logic is_misaligned(input logic [1:0] size, input logic [1:0] off);
        case (size)
            2'b00:   return 1'b0;
            2'b01:   return off[0];
            2'b10:   return off != 2'b00;
            default: return 1'b1;
        endcase
    endfunction

    // Lanes from the first addressed byte up to the access length
    function automatic wb_l1_pkg::sel_t lane_sel(input logic [1:0] size, input logic [1:0] off);
        int nbytes;
        wb_l1_pkg::sel_t s;
        nbytes = 1 << size;
        s = '0;
        for (int b = 0; b < 4; b++) begin
            if (b >= off && b < off + nbytes)
                s[b] = 1'b1;
        end
        return s;
    endfunction

    function automatic wb_l1_pkg::word_t load_value(input wb_l1_pkg::word_t mem_word,
                                                    input logic [1:0] off,
                                                    input logic [1:0] size,
                                                    input logic uns);
        wb_l1_pkg::word_t w;
        w = mem_word >> (8 * off);
        case (size)
            2'b00:   return uns ? {24'h0, w[7:0]} : {{24{w[7]}}, w[7:0]};
            2'b01:   return uns ? {16'h0, w[15:0]} : {{16{w[15]}}, w[15:0]};
            default: return w;
        endcase
    endfunction

    task automatic value_error(input string name, input logic [31:0] exp,
                               input logic [31:0] act);
        $display("[ERROR] %s expected %h got %h at %0t", name, exp, act, $time);
        data_errors++;
    endtask

    task automatic fault(input string msg);
        $display("Check failed at %0t: %s", $time, msg);
        fault_errors++;
    endtask

    initial begin
        data_errors = 0;
        fault_errors = 0;
        for (int i = 0; i < 256; i++) begin
            shadow[i] = fill_word(8'(i));
        end
    end

    always @(posedge clk) begin
        if (rst) begin
            f_pending = 1'b0;
            l_pending = 1'b0;
            seen_req = 1'b0;
            prev_cyc = 1'b0;
            prev_end = 1'b0;
            both_wait = 1'b0;
            end_both = 1'b0;
            have_owner = 1'b0;
            last_ls = 1'b0;
            cycle_no = 0;
            bus_starts = 0;
            expected_starts = 0;
        end else begin
            cycle_no++;

            // Quiet outputs between reset and the first request
            if (!seen_req && (wb_cyc | wb_stb | if_busy | ls_busy | if_rsp_valid | ls_rsp_valid))
                fault("outputs active after reset before any request");
            if (if_req | ls_req)
                seen_req = 1'b1;

            // Wishbone classic protocol
            if (wb_cyc != wb_stb)
                fault("wb_cyc and wb_stb differ");
            if (prev_cyc && !prev_end) begin
                if (!wb_cyc)
                    fault("bus cycle dropped before ack or err");
                else if (wb_adr !== prev_adr || wb_dat_w !== prev_dat ||
                         wb_sel !== prev_sel || wb_we !== prev_we)
                    fault("master outputs changed during a bus cycle");
            end
            if (prev_cyc && prev_end && wb_cyc)
                fault("bus cycle not closed the cycle after ack or err");
            if (wb_cyc && !prev_cyc)
                bus_starts++;

            if (if_rsp_valid) begin
                if (!f_pending) begin
                    fault("fetch response without a request");
                end else begin
                    if (f_ends > 2)
                        fault("fetch waited for more than one data bus cycle");
                    if (end_both && have_owner && !last_ls)
                        fault("fetch granted twice in a row while the data port waited");
                    have_owner = 1'b1;
                    last_ls = 1'b0;
                    if (if_rsp_err !== region_err(f_idx))
                        value_error("if_rsp_err", 32'(region_err(f_idx)), 32'(if_rsp_err));
                    else if (!if_rsp_err && if_rsp_data !== shadow[f_idx])
                        value_error("if_rsp_data", shadow[f_idx], if_rsp_data);
                end
                f_pending = 1'b0;
            end

            if (ls_rsp_valid) begin
                if (!l_pending) begin
                    fault("load/store response without a request");
                end else if (l_mis) begin
                    if (cycle_no != l_accept + 1)
                        fault("misaligned access not answered one cycle after acceptance");
                    if (ls_rsp_err !== 1'b1)
                        value_error("ls_rsp_err", 32'h1, 32'(ls_rsp_err));
                    if (ls_rsp_data !== '0)
                        value_error("ls_rsp_data", 32'h0, ls_rsp_data);
                end else begin
                    if (l_ends > 2)
                        fault("data access waited for more than one fetch bus cycle");
                    if (end_both && have_owner && last_ls)
                        fault("data port granted twice in a row while a fetch waited");
                    have_owner = 1'b1;
                    last_ls = 1'b1;
                    exp_word = l_we ? '0 : load_value(shadow[l_idx], l_off, l_size, l_uns);
                    if (ls_rsp_err !== region_err(l_idx))
                        value_error("ls_rsp_err", 32'(region_err(l_idx)), 32'(ls_rsp_err));
                    else if (!ls_rsp_err && ls_rsp_data !== exp_word)
                        value_error("ls_rsp_data", exp_word, ls_rsp_data);
                end
                l_pending = 1'b0;
            end

            // Both requests at the arbiter when this bus cycle was granted
            if (wb_cyc && !prev_cyc)
                both_wait = f_pending && (f_accept <= cycle_no - 2) &&
                            l_pending && !l_mis && (l_accept <= cycle_no - 2);

            // Bus cycle end, store lanes and shadow update
            if (wb_cyc && (wb_ack || wb_err)) begin
                end_both = both_wait;
                if (wb_we) begin
                    if (!(l_pending && l_we && !l_mis)) begin
                        fault("write cycle without a pending store");
                    end else begin
                        exp_sel = lane_sel(l_size, l_off);
                        exp_word = l_wdata << (8 * l_off);
                        lane_mask = '0;
                        for (int b = 0; b < 4; b++) begin
                            if (exp_sel[b])
                                lane_mask[8*b +: 8] = 8'hff;
                        end
                        if (wb_adr !== 30'(l_idx))
                            value_error("wb_adr", 32'(l_idx), 32'(wb_adr));
                        if (wb_sel !== exp_sel)
                            value_error("wb_sel", 32'(exp_sel), 32'(wb_sel));
                        if ((wb_dat_w & lane_mask) !== (exp_word & lane_mask))
                            value_error("wb_dat_w", exp_word & lane_mask, wb_dat_w & lane_mask);
                    end
                    if (wb_ack) begin
                        for (int b = 0; b < 4; b++) begin
                            if (wb_sel[b])
                                shadow[wb_adr[7:0]][8*b +: 8] = wb_dat_w[8*b +: 8];
                        end
                    end
                end
                if (f_pending)
                    f_ends++;
                if (l_pending)
                    l_ends++;
            end

            if (if_req && !if_busy) begin
                f_pending = 1'b1;
                f_idx = if_addr[9:2];
                f_accept = cycle_no;
                f_ends = 0;
                expected_starts++;
            end
            if (ls_req && !ls_busy) begin
                l_pending = 1'b1;
                l_idx = ls_addr[9:2];
                l_off = ls_addr[1:0];
                l_size = ls_size;
                l_uns = ls_unsigned;
                l_we = ls_we;
                l_wdata = ls_wdata;
                l_mis = is_misaligned(ls_size, ls_addr[1:0]);
                l_accept = cycle_no;
                l_ends = 0;
                if (!l_mis)
                    expected_starts++;
            end

            if (end_check) begin
                if (bus_starts != expected_starts)
                    fault($sformatf("%0d bus cycles seen, %0d expected",
                                    bus_starts, expected_starts));
                if (f_pending || l_pending)
                    fault("request left without a response");
            end

            prev_cyc = wb_cyc;
            prev_end = wb_ack | wb_err;
            prev_adr = wb_adr;
            prev_dat = wb_dat_w;
            prev_sel = wb_sel;
            prev_we = wb_we;
        end
    end

endmodule

// File: verification/tb_top.sv
/*
 * Test top for the L1 bus wrapper
 * DUT, LFSR driven requests on both ports,
 * Wishbone slave memory with wait states, watchdog
 */

`timescale 1ns/1ps

module tb_top;

    localparam int NUM_REQ = 400;

    logic clk;
    logic rst;
    logic if_req;
    wb_l1_pkg::byte_addr_t if_addr;
    logic if_busy;
    logic if_rsp_valid;
    wb_l1_pkg::word_t if_rsp_data;
    logic if_rsp_err;
    logic ls_req;
    wb_l1_pkg::byte_addr_t ls_addr;
    logic ls_we;
    wb_l1_pkg::access_size_t ls_size;
    logic ls_unsigned;
    wb_l1_pkg::word_t ls_wdata;
    logic ls_busy;
    logic ls_rsp_valid;
    wb_l1_pkg::word_t ls_rsp_data;
    logic ls_rsp_err;
    wb_l1_pkg::wb_adr_t wb_adr;
    wb_l1_pkg::word_t wb_dat_w;
    wb_l1_pkg::sel_t wb_sel;
    logic wb_cyc;
    logic wb_stb;
    logic wb_we;
    wb_l1_pkg::word_t wb_dat_r = '0;
    logic wb_ack = 1'b0;
    logic wb_err = 1'b0;
    logic end_check;
    int data_errors;
    int fault_errors;

    logic [31:0] lfsr = 32'h3121;
    wb_l1_pkg::word_t mem [0:255];
    logic slave_active;
    logic [1:0] wait_left;
    logic [1:0] wait_draw;

    tb_clock u_clock (.clk(clk));

    l1_bus_wrapper u_l1_bus_wrapper (.*);

    tb_checker u_checker (.*);

    // Fibonacci LFSR, taps 32 22 2 1, one step per bit
    function automatic logic [31:0] rand_bits(input int n);
        logic [31:0] v;
        logic fb;
        v = '0;
        for (int k = 0; k < n; k++) begin
            fb = lfsr[31] ^ lfsr[21] ^ lfsr[1] ^ lfsr[0];
            lfsr = {lfsr[30:0], fb};
            v = {v[30:0], fb};
        end
        return v;
    endfunction

    initial begin
        for (int i = 0; i < 256; i++) begin
            mem[i] = {8'(i) ^ 8'ha5, 8'(i) + 8'h3c, ~8'(i), 8'(i) * 8'd7};
        end
    end

    // Wishbone slave, 0 to 3 wait states, err in the top quarter
    always @(posedge clk) begin
        if (rst) begin
            wb_ack <= 1'b0;
            wb_err <= 1'b0;
            slave_active <= 1'b0;
        end else begin
            wb_ack <= 1'b0;
            wb_err <= 1'b0;
            if (wb_cyc && wb_stb && !wb_ack && !wb_err) begin
                if (!slave_active) begin
                    wait_draw = 2'(rand_bits(2));
                end
                if ((!slave_active && wait_draw == 2'd0) || (slave_active && wait_left == 2'd1)) begin
                    slave_active <= 1'b0;
                    if (wb_adr[7:6] == 2'b11) begin
                        wb_err <= 1'b1;
                    end else begin
                        wb_ack <= 1'b1;
                        wb_dat_r <= mem[wb_adr[7:0]];
                        for (int b = 0; b < 4; b++) begin
                            if (wb_we && wb_sel[b])
                                mem[wb_adr[7:0]][8*b +: 8] <= wb_dat_w[8*b +: 8];
                        end
                    end
                end else if (!slave_active) begin
                    slave_active <= 1'b1;
                    wait_left <= wait_draw;
                end else begin
                    wait_left <= wait_left - 2'd1;
                end
            end
        end
    end

    task automatic issue_fetches(input int count);
        int gap;
        for (int n = 0; n < count; n++) begin
            gap = int'(rand_bits(2));
            repeat (gap) @(negedge clk);
            while (if_busy) @(negedge clk);
            if_addr = rand_bits(10);
            if_req = 1'b1;
            @(negedge clk);
            if_req = 1'b0;
        end
    endtask

    task automatic issue_loads_stores(input int count);
        int gap;
        logic [1:0] size;
        for (int n = 0; n < count; n++) begin
            gap = int'(rand_bits(2));
            repeat (gap) @(negedge clk);
            while (ls_busy) @(negedge clk);
            size = 2'(rand_bits(2));
            ls_size = (size == 2'b11) ? wb_l1_pkg::SIZE_WORD : size;
            ls_addr = rand_bits(10);
            ls_unsigned = rand_bits(1) != 0;
            ls_we = rand_bits(1) != 0;
            ls_wdata = rand_bits(32);
            ls_req = 1'b1;
            @(negedge clk);
            ls_req = 1'b0;
        end
    endtask

    initial begin
        rst = 1'b1;
        if_req = 1'b0;
        if_addr = '0;
        ls_req = 1'b0;
        ls_addr = '0;
        ls_we = 1'b0;
        ls_size = wb_l1_pkg::SIZE_WORD;
        ls_unsigned = 1'b0;
        ls_wdata = '0;
        end_check = 1'b0;
        repeat (3) @(posedge clk);
        @(negedge clk);
        rst = 1'b0;
        fork
            issue_fetches(NUM_REQ);
            issue_loads_stores(NUM_REQ);
        join
        while (if_busy || ls_busy) @(negedge clk);
        repeat (4) @(negedge clk);
        end_check = 1'b1;
        @(negedge clk);
        end_check = 1'b0;
        @(negedge clk);
        $display("Errors: %0d data, %0d protocol", data_errors, fault_errors);
        if (data_errors == 0 && fault_errors == 0) begin
            $display("Simulation completed successfully");
        end else begin
            $display("Simulation failed");
        end
        $finish;
    end

    // Watchdog, 30 cycles per request
    initial begin
        #(NUM_REQ * 30 * 4);
        $display("Timeout: requests did not complete in time");
        $display("Simulation failed");
        $finish;
    end

endmodule

// File: wb_l1.f
+incdir+include
logic/wb_l1_pkg.sv
logic/fetch_port.sv
logic/data_port.sv
logic/wb_arbiter.sv
logic/l1_bus_wrapper.sv
verification/tb_clock.sv
verification/tb_checker.sv
verification/tb_top.sv

// File: Makefile
# Verilator build and run of the L1 bus wrapper testbench

RTL = logic/wb_l1_pkg.sv logic/fetch_port.sv logic/data_port.sv \
      logic/wb_arbiter.sv logic/l1_bus_wrapper.sv

.PHONY: all build run lint clean

all: run

build:
	verilator --binary --timing --assert -Wno-fatal -f wb_l1.f --top-module tb_top -o Vtb_top

run: build
	@out="$$(./obj_dir/Vtb_top)"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "Simulation completed successfully"

lint:
	verilator --lint-only -Wall -Iinclude $(RTL) --top-module l1_bus_wrapper

clean:
	rm -rf obj_dir
